//--- source/sub_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtraction unit shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package sub_pkg;

    // opcode field width
    localparam int SUB_OP_W = 2;

    // operation select
    typedef enum logic [SUB_OP_W-1:0] {
        // a - b
        OP_SUB  = 2'd0,
        // b - a
        OP_RSUB = 2'd1,
        // 0 - a
        OP_NEG  = 2'd2,
        // flags of a - b, result held
        OP_CMP  = 2'd3
    } sub_op_e;

endpackage : sub_pkg

`default_nettype wire

//--- source/sub_operand_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtraction unit operand register stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sub_operand_stage
    import sub_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire sub_op_e          op,
    input  wire logic [WIDTH-1:0] a,
    input  wire logic [WIDTH-1:0] b,
    output logic                  valid_q,
    output sub_op_e               op_q,
    output logic [WIDTH-1:0]      minuend,
    output logic [WIDTH-1:0]      subtrahend
);

    // strobe delayed by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // operands only move on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q <= op;
            case (op)
                OP_RSUB: begin
                    minuend    <= b;
                    subtrahend <= a;
                end
                OP_NEG: begin
                    minuend    <= '0;
                    subtrahend <= a;
                end
                // subtract and compare share the same ordering
                default: begin
                    minuend    <= a;
                    subtrahend <= b;
                end
            endcase
        end
    end

endmodule : sub_operand_stage

`default_nettype wire

//--- source/brentkung_subtractor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Brent-Kung parallel prefix subtractor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module brentkung_subtractor #(
    parameter int WIDTH = 16
) (
    input  wire logic [WIDTH-1:0] minuend,
    input  wire logic [WIDTH-1:0] subtrahend,
    output logic [WIDTH-1:0]      diff,
    output logic                  carry_out,
    output logic                  overflow
);

    localparam int LOG_W = $clog2(WIDTH);
    // stage 0 holds bit terms, then up-sweep and down-sweep levels
    localparam int NUM_STAGES = 2 * LOG_W;
    localparam int LAST = NUM_STAGES - 1;

    logic [WIDTH-1:0] sub_inv;
    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;
    logic [WIDTH:0]   carry;

    // group generate / propagate per stage
    logic [NUM_STAGES-1:0][WIDTH-1:0] gs;
    logic [NUM_STAGES-1:0][WIDTH-1:0] ps;

    generate
        if ((WIDTH < 8) || ((1 << LOG_W) != WIDTH)) begin : g_width_check
            $error("brentkung_subtractor needs a power-of-two WIDTH of 8 or more");
        end
    endgenerate

    // two's complement: a + ~b + 1
    assign sub_inv = ~subtrahend;
    assign g       = minuend & sub_inv;
    assign p       = minuend ^ sub_inv;

    // carry-in of one folded into bit 0
    assign gs[0][0] = g[0] | p[0];
    assign ps[0][0] = 1'b0;

    genvar s, i;
    generate
        for (i = 1; i < WIDTH; i++) begin : g_bit
            assign gs[0][i] = g[i];
            assign ps[0][i] = p[i];
        end

        for (s = 1; s < NUM_STAGES; s++) begin : g_stage
            // span doubles going up, then halves coming down
            localparam int SPAN = (s <= LOG_W) ? (1 << (s - 1))
                                               : (1 << (NUM_STAGES - 1 - s));
            localparam bit UP = (s <= LOG_W);

            for (i = 0; i < WIDTH; i++) begin : g_node
                localparam bit ACTIVE = UP ? (((i + 1) % (2 * SPAN)) == 0)
                                           : ((((i + 1) % (2 * SPAN)) == SPAN) &&
                                              (i >= 2 * SPAN));
                if (ACTIVE) begin : g_combine
                    assign gs[s][i] = gs[s-1][i] | (ps[s-1][i] & gs[s-1][i-SPAN]);
                    assign ps[s][i] = ps[s-1][i] & ps[s-1][i-SPAN];
                end else begin : g_pass
                    assign gs[s][i] = gs[s-1][i];
                    assign ps[s][i] = ps[s-1][i];
                end
            end
        end
    endgenerate

    // prefix generate at bit i is the carry into bit i+1
    assign carry[0]       = 1'b1;
    assign carry[WIDTH:1] = gs[LAST];

    assign diff      = p ^ carry[WIDTH-1:0];
    // high means no borrow
    assign carry_out = carry[WIDTH];
    assign overflow  = carry[WIDTH] ^ carry[WIDTH-1];

endmodule : brentkung_subtractor

`default_nettype wire

//--- source/sub_result_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtraction unit result and flag stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sub_result_stage
    import sub_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             valid_q,
    input  wire sub_op_e          op_q,
    input  wire logic [WIDTH-1:0] diff,
    input  wire logic             carry_out,
    input  wire logic             overflow,
    output logic [WIDTH-1:0]      result,
    output logic                  zero,
    output logic                  negative,
    output logic                  borrow,
    output logic                  ovf_flag,
    output logic                  out_valid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            result    <= '0;
            zero      <= 1'b0;
            negative  <= 1'b0;
            borrow    <= 1'b0;
            ovf_flag  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_q;
            if (valid_q) begin
                zero     <= (diff == '0);
                negative <= diff[WIDTH-1];
                borrow   <= ~carry_out;
                ovf_flag <= overflow;
                // compare only touches the flags
                if (op_q != OP_CMP) begin
                    result <= diff;
                end
            end
        end
    end

endmodule : sub_result_stage

`default_nettype wire

//--- source/sub_unit_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined subtraction unit top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sub_unit_top
    import sub_pkg::*;
#(
    parameter int WIDTH = 16
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire sub_op_e          op,
    input  wire logic [WIDTH-1:0] a,
    input  wire logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0]      result,
    output logic                  zero,
    output logic                  negative,
    output logic                  borrow,
    output logic                  ovf_flag,
    output logic                  out_valid
);

    // operand stage outputs
    logic             valid_q;
    sub_op_e          op_q;
    logic [WIDTH-1:0] minuend;
    logic [WIDTH-1:0] subtrahend;

    // prefix core outputs
    logic [WIDTH-1:0] diff;
    logic             carry_out;
    logic             overflow;

    sub_operand_stage #(
        .WIDTH(WIDTH)
    ) operand_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .op         (op),
        .a          (a),
        .b          (b),
        .valid_q    (valid_q),
        .op_q       (op_q),
        .minuend    (minuend),
        .subtrahend (subtrahend)
    );

    brentkung_subtractor #(
        .WIDTH(WIDTH)
    ) core_i (
        .minuend    (minuend),
        .subtrahend (subtrahend),
        .diff       (diff),
        .carry_out  (carry_out),
        .overflow   (overflow)
    );

    sub_result_stage #(
        .WIDTH(WIDTH)
    ) result_i (
        .clk        (clk),
        .rst        (rst),
        .valid_q    (valid_q),
        .op_q       (op_q),
        .diff       (diff),
        .carry_out  (carry_out),
        .overflow   (overflow),
        .result     (result),
        .zero       (zero),
        .negative   (negative),
        .borrow     (borrow),
        .ovf_flag   (ovf_flag),
        .out_valid  (out_valid)
    );

endmodule : sub_unit_top

`default_nettype wire

//--- bench/sub_unit_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtraction unit port properties
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sub_unit_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic in_valid,
    input wire logic out_valid,
    input wire logic zero,
    input wire logic negative
);

    // no output pulse while reset is applied or on the cycle after
    quiet_around_reset: assert property (
        @(posedge clk) rst |=> !out_valid ##1 !out_valid
    ) else $error("out_valid high during or just after reset");

    // every strobe comes out two cycles later
    strobe_to_pulse: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ##2 out_valid
    ) else $error("out_valid missing two cycles after in_valid");

    // and nothing comes out without a strobe
    pulse_from_strobe: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 2)
    ) else $error("out_valid without in_valid two cycles earlier");

    // a zero difference has a clear sign bit
    zero_not_negative: assert property (
        @(posedge clk) disable iff (rst) !(zero && negative)
    ) else $error("zero and negative both set");

endmodule : sub_unit_properties

bind sub_unit_top sub_unit_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .zero      (zero),
    .negative  (negative)
);

`default_nettype wire

//--- bench/sub_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subtraction unit testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module sub_unit_tb
    import sub_pkg::*;
;
    localparam int WIDTH       = 16;
    localparam int STIM_COLS   = 9;
    localparam int STIM_VECS   = 64;
    localparam int DRAIN_LIMIT = 40;

    logic             clk;
    logic             rst;
    logic             in_valid;
    sub_op_e          op;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] result;
    logic             zero;
    logic             negative;
    logic             borrow;
    logic             ovf_flag;
    logic             out_valid;

    logic [15:0]      stim_mem [0:STIM_COLS*STIM_VECS-1];
    logic [31:0]      lfsr_state = 32'h837a82f3;
    logic [WIDTH-1:0] model_result = '0;

    // pending operations in issue order
    logic [WIDTH-1:0] exp_result_q [$];
    logic [3:0]       exp_flags_q  [$];
    int               exp_cycle_q  [$];

    int cycle_cnt  = 0;
    int pulse_cnt  = 0;
    int check_cnt  = 0;
    int error_cnt  = 0;
    int check_base = 0;
    int error_base = 0;
    int tests_run  = 0;
    bit timed_out  = 1'b0;

    sub_unit_top #(
        .WIDTH(WIDTH)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .result    (result),
        .zero      (zero),
        .negative  (negative),
        .borrow    (borrow),
        .ovf_flag  (ovf_flag),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [WIDTH-1:0] random_bits(input int count);
        logic [WIDTH-1:0] value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            value      = {value[WIDTH-2:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        end
        return value;
    endfunction

    // reference arithmetic straight from the opcode definitions
    task automatic compute_expected(input sub_op_e op_v, input logic [WIDTH-1:0] a_v,
                                    input logic [WIDTH-1:0] b_v, input logic [WIDTH-1:0] prev,
                                    output logic [WIDTH-1:0] res, output logic [3:0] flags);
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] s;
        logic [WIDTH-1:0] d;
        case (op_v)
            OP_RSUB: begin
                m = b_v;
                s = a_v;
            end
            OP_NEG: begin
                m = '0;
                s = a_v;
            end
            default: begin
                m = a_v;
                s = b_v;
            end
        endcase
        d     = m - s;
        res   = (op_v == OP_CMP) ? prev : d;
        flags = {d == '0, d[WIDTH-1], m < s,
                 (m[WIDTH-1] != s[WIDTH-1]) && (d[WIDTH-1] != m[WIDTH-1])};
    endtask

    task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                               input logic [WIDTH-1:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic issue_op(input sub_op_e op_v, input logic [WIDTH-1:0] a_v,
                            input logic [WIDTH-1:0] b_v, input logic [WIDTH-1:0] exp_res,
                            input logic [3:0] exp_flags);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = op_v;
        a        = a_v;
        b        = b_v;
        exp_result_q.push_back(exp_res);
        exp_flags_q.push_back(exp_flags);
        // cycle in which the strobe is high
        exp_cycle_q.push_back(cycle_cnt);
        model_result = exp_res;
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((exp_result_q.size() != 0) && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("Timeout: %s still waiting for %0d results", what, exp_result_q.size());
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic begin_test();
        check_base = check_cnt;
        error_base = error_cnt;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d checks, %0d errors", tests_run, name,
                 check_cnt - check_base, error_cnt - error_base);
    endtask

    // vectors for one test number, issued back to back
    task automatic run_file_test(input int test_no, input string name);
        int         idx;
        int         base;
        logic [3:0] flags;
        begin_test();
        idx = 0;
        while ((idx < STIM_VECS) && (stim_mem[idx*STIM_COLS] != 16'h0)) begin
            base = idx * STIM_COLS;
            if (stim_mem[base] == 16'(test_no)) begin
                flags = {stim_mem[base+5][0], stim_mem[base+6][0],
                         stim_mem[base+7][0], stim_mem[base+8][0]};
                issue_op(sub_op_e'(stim_mem[base+1][SUB_OP_W-1:0]), stim_mem[base+2],
                         stim_mem[base+3], stim_mem[base+4], flags);
            end
            idx++;
        end
        idle_inputs();
        wait_drain(name);
        report_test(name);
    endtask

    task automatic run_random_test(input int count);
        logic [WIDTH-1:0] r;
        logic [WIDTH-1:0] a_v;
        logic [WIDTH-1:0] b_v;
        logic [WIDTH-1:0] res;
        logic [3:0]       flags;
        int               pulse_base;
        sub_op_e          op_v;
        begin_test();
        pulse_base = pulse_cnt;
        for (int k = 0; k < count; k++) begin
            r    = random_bits(SUB_OP_W);
            op_v = sub_op_e'(r[SUB_OP_W-1:0]);
            a_v  = random_bits(WIDTH);
            b_v  = random_bits(WIDTH);
            compute_expected(op_v, a_v, b_v, model_result, res, flags);
            issue_op(op_v, a_v, b_v, res, flags);
        end
        idle_inputs();
        wait_drain("back-to-back");
        check_cnt++;
        assert (pulse_cnt - pulse_base == count) else begin
            $display("saw %0d out_valid pulses for %0d operations", pulse_cnt - pulse_base, count);
            error_cnt++;
        end
        report_test("back-to-back");
    endtask

    task automatic run_reset_test();
        logic [WIDTH-1:0] res;
        logic [3:0]       flags;
        int               pulse_base;
        begin_test();
        pulse_base = pulse_cnt;
        compute_expected(OP_SUB, 16'h0040, 16'h0001, model_result, res, flags);
        issue_op(OP_SUB, 16'h0040, 16'h0001, res, flags);
        compute_expected(OP_NEG, 16'h0011, 16'h0000, model_result, res, flags);
        issue_op(OP_NEG, 16'h0011, 16'h0000, res, flags);
        // reset is sampled with the second strobe, the first one still in the pipe
        rst = 1'b1;
        exp_result_q.delete();
        exp_flags_q.delete();
        exp_cycle_q.delete();
        model_result = '0;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("result", result, '0);
        check_value("zero", 16'(zero), '0);
        check_value("negative", 16'(negative), '0);
        check_value("borrow", 16'(borrow), '0);
        check_value("ovf_flag", 16'(ovf_flag), '0);
        check_value("out_valid", 16'(out_valid), '0);
        repeat (6) @(posedge clk);
        // compare after reset holds the cleared result
        compute_expected(OP_CMP, 16'h0005, 16'h0003, model_result, res, flags);
        issue_op(OP_CMP, 16'h0005, 16'h0003, res, flags);
        idle_inputs();
        wait_drain("reset");
        check_cnt++;
        assert (pulse_cnt - pulse_base == 1) else begin
            $display("saw %0d out_valid pulses around reset, expected 1", pulse_cnt - pulse_base);
            error_cnt++;
        end
        report_test("reset");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : monitor_outputs
        logic [WIDTH-1:0] exp_res;
        logic [3:0]       exp_flags;
        int               exp_cycle;
        if (out_valid) begin
            pulse_cnt++;
            check_cnt++;
            assert (exp_result_q.size() != 0) else begin
                $display("out_valid pulsed with no operation pending");
                error_cnt++;
            end
            if (exp_result_q.size() != 0) begin
                exp_res   = exp_result_q.pop_front();
                exp_flags = exp_flags_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_value("result", result, exp_res);
                check_value("zero", 16'(zero), 16'(exp_flags[3]));
                check_value("negative", 16'(negative), 16'(exp_flags[2]));
                check_value("borrow", 16'(borrow), 16'(exp_flags[1]));
                check_value("ovf_flag", 16'(ovf_flag), 16'(exp_flags[0]));
                check_cnt++;
                assert (cycle_cnt == exp_cycle + 2) else begin
                    $display("out_valid came in cycle %0d, expected cycle %0d",
                             cycle_cnt, exp_cycle + 2);
                    error_cnt++;
                end
            end
        end
    end

    initial begin : run_tests
        rst      = 1'b1;
        in_valid = 1'b0;
        op       = OP_SUB;
        a        = '0;
        b        = '0;
        $readmemh("bench/sub_stim.txt", stim_mem);
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        if (!timed_out) run_file_test(1, "subtract");
        if (!timed_out) run_file_test(2, "reverse and negate");
        if (!timed_out) run_file_test(3, "compare");
        if (!timed_out) run_random_test(200);
        if (!timed_out) run_reset_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_cnt, error_cnt);
        if (timed_out || (error_cnt != 0) || (check_cnt == 0)) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule : sub_unit_tb

`default_nettype wire

//--- bench/sub_stim.txt
// columns (hex): test op a b result zero negative borrow overflow
// op 0 sub, 1 reverse sub, 2 negate, 3 compare; a test number of 0 ends the list
// test 1 subtract
1 0 0005 0003 0002 0 0 0 0
1 0 1234 1234 0000 1 0 0 0
1 0 0003 0005 fffe 0 1 1 0
1 0 8000 0001 7fff 0 0 0 1
1 0 7fff ffff 8000 0 1 1 1
1 0 0000 0000 0000 1 0 0 0
1 0 ffff 0001 fffe 0 1 0 0
1 0 0000 0001 ffff 0 1 1 0
1 0 8000 7fff 0001 0 0 0 1
1 0 7fff 8000 ffff 0 1 1 1
1 0 abcd 1234 9999 0 1 0 0
1 0 1234 abcd 6667 0 0 1 0
1 0 8000 8000 0000 1 0 0 0
1 0 ffff ffff 0000 1 0 0 0
// test 2 reverse subtract and negate
2 1 0003 0005 0002 0 0 0 0
2 1 0005 0003 fffe 0 1 1 0
2 1 0001 8000 7fff 0 0 0 1
2 1 1111 1111 0000 1 0 0 0
2 2 0000 1234 0000 1 0 0 0
2 2 0001 0000 ffff 0 1 1 0
2 2 8000 0000 8000 0 1 1 1
2 2 7fff 0000 8001 0 1 1 0
2 2 ffff 5555 0001 0 0 1 0
2 1 ffff 0000 0001 0 0 1 0
// test 3 compare holds the last result
3 0 0100 0040 00c0 0 0 0 0
3 3 0002 0009 00c0 0 1 1 0
3 3 0007 0007 00c0 1 0 0 0
3 3 8000 0001 00c0 0 0 0 1
3 0 0050 0010 0040 0 0 0 0
3 3 0010 0050 0040 0 1 1 0
3 3 7fff ffff 0040 0 1 1 1
3 1 0010 0030 0020 0 0 0 0
3 3 ffff ffff 0020 1 0 0 0
3 2 0020 0000 ffe0 0 1 1 0
3 3 0000 0001 ffe0 0 1 1 0
// end of vectors
0 0 0000 0000 0000 0 0 0 0

//--- sim.f
source/sub_pkg.sv
source/sub_operand_stage.sv
source/brentkung_subtractor.sv
source/sub_result_stage.sv
source/sub_unit_top.sv
bench/sub_unit_properties.sv
bench/sub_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sub_unit_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
